/* Bender.yml */
package:
  name: decoder_control

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/decoderPkg.sv
      - design/instrClassifier.sv
      - design/phaseSequencer.sv
      - design/datapathControl.sv
      - design/memAccessControl.sv
      - design/decoderTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/decoderTb.sv

/* design/datapathControl.sv */
`timescale 1ns/1ps
`default_nettype none

module datapathControl (
  input  decoderPkg::phase_t phase,
  input  decoderPkg::decodedInstr_t decoded,
  input  logic branchDelay,
  input  logic aluFlag,
  output decoderPkg::aluCtrl_t aluCtrl,
  output decoderPkg::regCtrl_t regCtrl,
  output decoderPkg::pcCtrl_t pcCtrl,
  output logic needsMore,
  output logic branchTaken
);

  import decoderPkg::*;

  always_comb begin
    aluCtrl = '0;
    regCtrl = '0;
    pcCtrl = '0;
    needsMore = 1'b0;
    branchTaken = 1'b0;
    case (phase)
      FETCH: begin
        // PC + 4, or the saved target when a branch is pending
        aluCtrl.srcB = 2'b01;
        aluCtrl.aluOp = ALU_ADD;
        pcCtrl.pcWrite = 1'b1;
        pcCtrl.pcSrc = branchDelay;
      end
      DECODE: begin
        // Branch target computed ahead of the compare
        aluCtrl.srcB = 2'b11;
        aluCtrl.aluOp = ALU_BRANCH_TARGET;
        pcCtrl.irWrite = 1'b1;
      end
      EXEC1: begin
        pcCtrl.irSel = 1'b1;
        if (decoded.instrClass != CLS_INVALID) begin
          aluCtrl.aluOp = decoded.aluOp;
          aluCtrl.extSel = decoded.zeroExtImm;
          aluCtrl.srcA = (decoded.instrClass != CLS_JUMP);
        end
        case (decoded.instrClass)
          CLS_ALU_REG: needsMore = 1'b1;
          CLS_ALU_IMM, CLS_LOAD, CLS_STORE: begin
            aluCtrl.srcB = 2'b10;
            needsMore = 1'b1;
          end
          CLS_BRANCH: begin
            // aluFlag is the equality result
            aluCtrl.aluSel = 1'b1;
            branchTaken = decoded.branchOnEqual ? aluFlag : !aluFlag;
          end
          CLS_JUMP: begin
            aluCtrl.srcB = 2'b11;
            pcCtrl.isJump = 1'b1;
            branchTaken = 1'b1;
          end
          CLS_JUMP_REG: branchTaken = 1'b1;
          default: ;
        endcase
      end
      EXEC2: begin
        pcCtrl.irSel = 1'b1;
        case (decoded.instrClass)
          CLS_ALU_REG, CLS_ALU_IMM: begin
            aluCtrl.aluSel = 1'b1;
            regCtrl.regWrite = 1'b1;
            regCtrl.memToReg = 1'b1;
            regCtrl.regDst = (decoded.instrClass == CLS_ALU_REG);
          end
          CLS_LOAD: begin
            aluCtrl.aluSel = 1'b1;
            needsMore = 1'b1;
          end
          CLS_STORE: aluCtrl.aluSel = 1'b1;
          default: ;
        endcase
      end
      EXEC3: begin
        pcCtrl.irSel = 1'b1;
        // Load data written to rt
        regCtrl.regWrite = (decoded.instrClass == CLS_LOAD);
      end
      default: ;
    endcase
  end

  regWriteLegal: assert final (!regCtrl.regWrite
      || (phase == EXEC2 && decoded.instrClass inside {CLS_ALU_REG, CLS_ALU_IMM})
      || (phase == EXEC3 && decoded.instrClass == CLS_LOAD))
    else $error("regWrite in phase %s for class %s",
                phase.name(), decoded.instrClass.name());

endmodule

`default_nettype wire

/* design/decoderPkg.sv */
`default_nettype none

`include "decoder_macros.svh"

package decoderPkg;

  // Primary opcode field, MIPS encodings
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    R_TYPE = 6'b000000,
    J      = 6'b000010,
    BEQ    = 6'b000100,
    BNE    = 6'b000101,
    ADDIU  = 6'b001001,
    SLTI   = 6'b001010,
    ANDI   = 6'b001100,
    ORI    = 6'b001101,
    XORI   = 6'b001110,
    LUI    = 6'b001111,
    LB     = 6'b100000,
    LH     = 6'b100001,
    LW     = 6'b100011,
    LBU    = 6'b100100,
    LHU    = 6'b100101,
    SW     = 6'b101011
  } opcode_t;

  // 3'b111 is never entered
  typedef enum logic [2:0] {
    FETCH      = 3'b000,
    DECODE     = 3'b001,
    EXEC1      = 3'b010,
    EXEC2      = 3'b011,
    EXEC3      = 3'b100,
    HALTED     = 3'b101,
    FETCH_WAIT = 3'b110
  } phase_t;

  // Codes understood by the datapath ALU
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_AND           = 5'b00000,
    ALU_OR            = 5'b00001,
    ALU_ADD           = 5'b00010,
    ALU_XOR           = 5'b00011,
    ALU_SLT           = 5'b00111,
    ALU_CMP_EQ        = 5'b01010,
    ALU_BRANCH_TARGET = 5'b01101,
    ALU_PASS_A        = 5'b01110,
    ALU_FUNCT         = 5'b01111,
    ALU_JUMP_TARGET   = 5'b10001,
    ALU_LUI           = 5'b10100
  } aluOp_t;

  typedef enum logic [2:0] {
    CLS_ALU_REG,
    CLS_ALU_IMM,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JUMP,
    CLS_JUMP_REG,
    CLS_INVALID
  } instrClass_t;

  typedef enum logic [1:0] {
    MEM_WORD = 2'b00,
    MEM_HALF = 2'b01,
    MEM_BYTE = 2'b10
  } memSize_t;

  // Load extension applied by the memory read path
  typedef enum logic [1:0] {
    EXT_NONE      = 2'b00,
    EXT_SIGN_BYTE = 2'b10,
    EXT_SIGN_HALF = 2'b11
  } extMode_t;

  typedef struct packed {
    instrClass_t instrClass;
    aluOp_t      aluOp;
    logic        zeroExtImm;
    memSize_t    memSize;
    logic        loadSigned;
    logic        branchOnEqual;
    logic [6:0]  spare;
  } decodedInstr_t;

  typedef struct packed {
    logic       srcA;
    logic [1:0] srcB;
    aluOp_t     aluOp;
    logic       aluSel;
    logic       extSel;
    logic       reserved;
  } aluCtrl_t;

  typedef struct packed {
    logic                      memRead;
    logic                      memWrite;
    logic                      iOrD;
    logic [`BYTE_EN_WIDTH-1:0] byteEnable;
    extMode_t                  extMode;
  } memCtrl_t;

  typedef struct packed {
    logic regWrite;
    logic regDst;
    logic memToReg;
  } regCtrl_t;

  typedef struct packed {
    logic pcWrite;
    logic pcSrc;
    logic irWrite;
    logic irSel;
    logic isJump;
  } pcCtrl_t;

endpackage

`default_nettype wire

/* design/decoderTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decoder_macros.svh"

module decoderTop (
  input  logic clk,
  input  logic rst,
  input  logic run,
  input  logic [`INSTR_WIDTH-1:0] instr,
  input  logic pcIsZero,
  input  logic waitRequest,
  input  logic aluFlag,
  output decoderPkg::phase_t phase,
  output logic active,
  output decoderPkg::aluCtrl_t aluCtrl,
  output decoderPkg::memCtrl_t memCtrl,
  output decoderPkg::regCtrl_t regCtrl,
  output decoderPkg::pcCtrl_t pcCtrl
);

  import decoderPkg::*;

  decodedInstr_t decoded;
  logic branchDelay;
  logic needsMore;
  logic branchTaken;

  instrClassifier u_classifier (
    .instr   (instr),
    .decoded (decoded)
  );

  phaseSequencer u_sequencer (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .pcIsZero    (pcIsZero),
    .waitRequest (waitRequest),
    .needsMore   (needsMore),
    .branchTaken (branchTaken),
    .phase       (phase),
    .branchDelay (branchDelay),
    .active      (active)
  );

  // Branch decision returns to the sequencer for the next fetch
  datapathControl u_datapathCtrl (
    .phase       (phase),
    .decoded     (decoded),
    .branchDelay (branchDelay),
    .aluFlag     (aluFlag),
    .aluCtrl     (aluCtrl),
    .regCtrl     (regCtrl),
    .pcCtrl      (pcCtrl),
    .needsMore   (needsMore),
    .branchTaken (branchTaken)
  );

  memAccessControl u_memCtrl (
    .phase   (phase),
    .decoded (decoded),
    .memCtrl (memCtrl)
  );

endmodule

`default_nettype wire

/* design/instrClassifier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decoder_macros.svh"

module instrClassifier (
  input  logic [`INSTR_WIDTH-1:0] instr,
  output decoderPkg::decodedInstr_t decoded
);

  import decoderPkg::*;

  localparam logic [`FUNCT_WIDTH-1:0] FUNCT_JR = 6'b001000;

  opcode_t opcode;
  logic [`FUNCT_WIDTH-1:0] funct;

  assign opcode = opcode_t'(instr[`INSTR_WIDTH-1 -: `OPCODE_WIDTH]);
  assign funct = instr[`FUNCT_WIDTH-1:0];

  always_comb begin
    decoded = '0;
    decoded.instrClass = CLS_INVALID;
    decoded.aluOp = ALU_AND;
    decoded.memSize = MEM_WORD;
    case (opcode)
      R_TYPE: begin
        if (funct == FUNCT_JR) begin
          decoded.instrClass = CLS_JUMP_REG;
          decoded.aluOp = ALU_PASS_A;
        end else begin
          // ALU decodes the function field itself
          decoded.instrClass = CLS_ALU_REG;
          decoded.aluOp = ALU_FUNCT;
        end
      end
      ADDIU: begin
        decoded.instrClass = CLS_ALU_IMM;
        decoded.aluOp = ALU_ADD;
      end
      ANDI, ORI, XORI: begin
        decoded.instrClass = CLS_ALU_IMM;
        decoded.zeroExtImm = 1'b1;
        decoded.aluOp = (opcode == ANDI) ? ALU_AND : (opcode == ORI) ? ALU_OR : ALU_XOR;
      end
      SLTI: begin
        decoded.instrClass = CLS_ALU_IMM;
        decoded.aluOp = ALU_SLT;
      end
      LUI: begin
        decoded.instrClass = CLS_ALU_IMM;
        decoded.aluOp = ALU_LUI;
      end
      LW, LH, LHU, LB, LBU: begin
        decoded.instrClass = CLS_LOAD;
        decoded.aluOp = ALU_ADD;
        decoded.loadSigned = (opcode == LH) || (opcode == LB);
        if (opcode == LH || opcode == LHU) begin
          decoded.memSize = MEM_HALF;
        end else if (opcode == LB || opcode == LBU) begin
          decoded.memSize = MEM_BYTE;
        end
      end
      SW: begin
        decoded.instrClass = CLS_STORE;
        decoded.aluOp = ALU_ADD;
      end
      BEQ, BNE: begin
        decoded.instrClass = CLS_BRANCH;
        decoded.aluOp = ALU_CMP_EQ;
        decoded.branchOnEqual = (opcode == BEQ);
      end
      J: begin
        decoded.instrClass = CLS_JUMP;
        decoded.aluOp = ALU_JUMP_TARGET;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* design/memAccessControl.sv */
`timescale 1ns/1ps
`default_nettype none

module memAccessControl (
  input  decoderPkg::phase_t phase,
  input  decoderPkg::decodedInstr_t decoded,
  output decoderPkg::memCtrl_t memCtrl
);

  import decoderPkg::*;

  logic isLoad;
  logic isStore;

  assign isLoad = (decoded.instrClass == CLS_LOAD);
  assign isStore = (decoded.instrClass == CLS_STORE);

  always_comb begin
    memCtrl = '0;
    memCtrl.byteEnable = 4'b1111;
    memCtrl.extMode = EXT_NONE;
    memCtrl.memRead = (phase == FETCH) || (phase == FETCH_WAIT) || (phase == EXEC2 && isLoad);
    memCtrl.memWrite = (phase == EXEC2) && isStore;
    // Data access uses the ALU address
    memCtrl.iOrD = (phase == EXEC2) && (isLoad || isStore);
    if (memCtrl.iOrD) begin
      case (decoded.memSize)
        MEM_HALF: memCtrl.byteEnable = 4'b0011;
        MEM_BYTE: memCtrl.byteEnable = 4'b0001;
        default:  memCtrl.byteEnable = 4'b1111;
      endcase
    end
    // Extension held through write-back
    if (isLoad && decoded.loadSigned && (phase == EXEC2 || phase == EXEC3)) begin
      case (decoded.memSize)
        MEM_HALF: memCtrl.extMode = EXT_SIGN_HALF;
        MEM_BYTE: memCtrl.extMode = EXT_SIGN_BYTE;
        default:  memCtrl.extMode = EXT_NONE;
      endcase
    end
  end

  memOwnerUnique: assert final (!(memCtrl.memRead && memCtrl.memWrite))
    else $error("memRead and memWrite both high in phase %s", phase.name());

endmodule

`default_nettype wire

/* design/phaseSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
  input  logic clk,
  input  logic rst,
  input  logic run,
  input  logic pcIsZero,
  input  logic waitRequest,
  input  logic needsMore,
  input  logic branchTaken,
  output decoderPkg::phase_t phase,
  output logic branchDelay,
  output logic active
);

  import decoderPkg::*;

  phase_t phaseNext;
  // High in the execute phase that hands over to the next fetch
  logic lastExec;

  always_comb begin
    phaseNext = phase;
    lastExec = 1'b0;
    case (phase)
      HALTED: begin
        if (run) begin
          phaseNext = FETCH;
        end
      end
      FETCH, FETCH_WAIT: phaseNext = waitRequest ? FETCH_WAIT : DECODE;
      DECODE: phaseNext = EXEC1;
      EXEC1: begin
        phaseNext = needsMore ? EXEC2 : FETCH;
        lastExec = !needsMore;
      end
      EXEC2: begin
        // Held until the memory accepts the access
        if (!waitRequest) begin
          phaseNext = needsMore ? EXEC3 : FETCH;
          lastExec = !needsMore;
        end
      end
      EXEC3: begin
        phaseNext = FETCH;
        lastExec = 1'b1;
      end
      default: phaseNext = HALTED;
    endcase
    if (pcIsZero && phase != HALTED) begin
      phaseNext = HALTED;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= HALTED;
      branchDelay <= 1'b0;
    end else begin
      phase <= phaseNext;
      if (phase == HALTED) begin
        branchDelay <= 1'b0;
      end else if (lastExec) begin
        branchDelay <= branchTaken;
      end
    end
  end

  assign active = (phase != HALTED);

  haltNeedsRun: assert property (@(posedge clk) disable iff (rst)
    (phase == HALTED && !run) |=> (phase == HALTED))
    else $error("phase left HALTED without run");

  phaseLegal: assert property (@(posedge clk) disable iff (rst)
    phase inside {FETCH, FETCH_WAIT, DECODE, EXEC1, EXEC2, EXEC3, HALTED})
    else $error("phase holds unused encoding %b", phase);

endmodule

`default_nettype wire

/* include/decoder_macros.svh */
`ifndef DECODER_MACROS_SVH
`define DECODER_MACROS_SVH

// Instruction word and its fields
`define INSTR_WIDTH 32
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6

// Control word fields
`define ALU_OP_WIDTH 5
`define BYTE_EN_WIDTH 4

`endif

/* sim.f */
+incdir+include
design/decoderPkg.sv
design/instrClassifier.sv
design/phaseSequencer.sv
design/datapathControl.sv
design/memAccessControl.sv
design/decoderTop.sv
verification/decoderTb.sv

/* verification/decoderTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decoder_macros.svh"

module decoderTb;

  import decoderPkg::*;

  localparam int NUM_INSTR = 300;
  localparam int CLK_PERIOD = 8;
  localparam logic [`FUNCT_WIDTH-1:0] FUNCT_JR = 6'b001000;

  logic clk;
  logic rst;
  logic run;
  logic [`INSTR_WIDTH-1:0] instr;
  logic pcIsZero;
  logic waitRequest;
  logic aluFlag;
  phase_t phase;
  logic active;
  aluCtrl_t aluCtrl;
  memCtrl_t memCtrl;
  regCtrl_t regCtrl;
  pcCtrl_t pcCtrl;

  integer seed;
  int errorCount;
  int instrCount;
  logic fetching;
  logic [`INSTR_WIDTH-1:0] nextInstr;

  // Expected values from the control rules
  phase_t expPhase;
  logic expDelay;
  instrClass_t refCls;
  aluOp_t expAluOp;
  logic [`BYTE_EN_WIDTH-1:0] expByteEn;
  extMode_t expExt;
  logic expRegWrite;
  logic expMemRead;
  logic expMemWrite;
  logic expExtSel;
  logic [6:0] strobes;

  opcode_t opTable [16] = '{R_TYPE, LW, LB, LBU, LH, LHU, SW, ADDIU,
                            ANDI, ORI, XORI, SLTI, LUI, BEQ, BNE, J};

  decoderTop u_dut (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .instr       (instr),
    .pcIsZero    (pcIsZero),
    .waitRequest (waitRequest),
    .aluFlag     (aluFlag),
    .phase       (phase),
    .active      (active),
    .aluCtrl     (aluCtrl),
    .memCtrl     (memCtrl),
    .regCtrl     (regCtrl),
    .pcCtrl      (pcCtrl)
  );

  function automatic logic [`OPCODE_WIDTH-1:0] opOf(input logic [`INSTR_WIDTH-1:0] word);
    return word[`INSTR_WIDTH-1 -: `OPCODE_WIDTH];
  endfunction

  function automatic instrClass_t classOf(input logic [`INSTR_WIDTH-1:0] word);
    case (opOf(word))
      R_TYPE: return (word[`FUNCT_WIDTH-1:0] == FUNCT_JR) ? CLS_JUMP_REG : CLS_ALU_REG;
      ADDIU, ANDI, ORI, XORI, SLTI, LUI: return CLS_ALU_IMM;
      LW, LH, LHU, LB, LBU: return CLS_LOAD;
      SW: return CLS_STORE;
      BEQ, BNE: return CLS_BRANCH;
      J: return CLS_JUMP;
      default: return CLS_INVALID;
    endcase
  endfunction

  function automatic aluOp_t aluOpOf(input logic [`INSTR_WIDTH-1:0] word);
    case (opOf(word))
      R_TYPE: return (word[`FUNCT_WIDTH-1:0] == FUNCT_JR) ? ALU_PASS_A : ALU_FUNCT;
      ANDI: return ALU_AND;
      ORI: return ALU_OR;
      XORI: return ALU_XOR;
      SLTI: return ALU_SLT;
      LUI: return ALU_LUI;
      BEQ, BNE: return ALU_CMP_EQ;
      J: return ALU_JUMP_TARGET;
      // ADDIU and address calculation
      default: return ALU_ADD;
    endcase
  endfunction

  function automatic int execCount(input instrClass_t cls);
    case (cls)
      CLS_ALU_REG, CLS_ALU_IMM, CLS_STORE: return 2;
      CLS_LOAD: return 3;
      default: return 1;
    endcase
  endfunction

  function automatic phase_t nextPhase(input phase_t ph, input logic [`INSTR_WIDTH-1:0] word,
                                       input logic wr, input logic pz, input logic rn);
    int phases;
    phases = execCount(classOf(word));
    if (ph == HALTED) begin
      return rn ? FETCH : HALTED;
    end
    if (pz) begin
      return HALTED;
    end
    case (ph)
      FETCH, FETCH_WAIT: return wr ? FETCH_WAIT : DECODE;
      DECODE: return EXEC1;
      EXEC1: return (phases > 1) ? EXEC2 : FETCH;
      EXEC2: return wr ? EXEC2 : ((phases > 2) ? EXEC3 : FETCH);
      default: return FETCH;
    endcase
  endfunction

  function automatic logic branchRule(input logic [`INSTR_WIDTH-1:0] word, input logic flag);
    case (opOf(word))
      BEQ: return flag;
      BNE: return !flag;
      J: return 1'b1;
      R_TYPE: return word[`FUNCT_WIDTH-1:0] == FUNCT_JR;
      default: return 1'b0;
    endcase
  endfunction

  task automatic pickInstr(output logic [`INSTR_WIDTH-1:0] word);
    int idx;
    idx = $unsigned($random(seed)) % 16;
    word = $random(seed);
    word[`INSTR_WIDTH-1 -: `OPCODE_WIDTH] = opTable[idx];
    // Some R-types become JR
    if (opTable[idx] == R_TYPE && ($random(seed) & 3) == 0) begin
      word[`FUNCT_WIDTH-1:0] = FUNCT_JR;
    end
  endtask

  task automatic reportValue(input string testName, input int expected, input int actual);
    errorCount++;
    $display("error %s: expected %0h, actual %0h", testName, expected, actual);
  endtask

  always_comb begin
    refCls = classOf(instr);
    expAluOp = aluOpOf(instr);
    expExtSel = (expPhase == EXEC1) && (opOf(instr) inside {ANDI, ORI, XORI});
    expRegWrite = (expPhase == EXEC2 && refCls inside {CLS_ALU_REG, CLS_ALU_IMM})
        || (expPhase == EXEC3 && refCls == CLS_LOAD);
    expMemRead = (expPhase == FETCH) || (expPhase == FETCH_WAIT)
        || (expPhase == EXEC2 && refCls == CLS_LOAD);
    expMemWrite = (expPhase == EXEC2) && (refCls == CLS_STORE);
    case (opOf(instr))
      LH, LHU: expByteEn = 4'b0011;
      LB, LBU: expByteEn = 4'b0001;
      default: expByteEn = 4'b1111;
    endcase
    case (opOf(instr))
      LH: expExt = EXT_SIGN_HALF;
      LB: expExt = EXT_SIGN_BYTE;
      default: expExt = EXT_NONE;
    endcase
  end

  assign strobes = {active, memCtrl.memRead, memCtrl.memWrite, regCtrl.regWrite,
                    pcCtrl.pcWrite, pcCtrl.irWrite, pcCtrl.pcSrc};

  // Next phase and pending redirect, tracked one edge ahead
  always @(posedge clk) begin
    if (rst) begin
      expPhase <= HALTED;
      expDelay <= 1'b0;
    end else begin
      expPhase <= nextPhase(expPhase, instr, waitRequest, pcIsZero, run);
      if (expPhase == HALTED) begin
        expDelay <= 1'b0;
      end else if (expPhase inside {EXEC1, EXEC2, EXEC3}
          && nextPhase(expPhase, instr, waitRequest, 1'b0, run) == FETCH) begin
        expDelay <= branchRule(instr, aluFlag);
      end
    end
  end

  phaseStep: assert property (@(posedge clk) disable iff (rst) phase == expPhase)
    else reportValue("phase sequence", $sampled(expPhase), $sampled(phase));
  activeFlag: assert property (@(posedge clk) disable iff (rst)
    active == (expPhase != HALTED))
    else reportValue("active flag", $sampled(expPhase != HALTED), $sampled(active));
  haltedQuiet: assert property (@(posedge clk) disable iff (rst)
    (phase == HALTED) |-> (strobes == '0))
    else reportValue("halted outputs", 0, $sampled(strobes));
  regWritePlace: assert property (@(posedge clk) disable iff (rst)
    regCtrl.regWrite == expRegWrite)
    else reportValue("regWrite", $sampled(expRegWrite), $sampled(regCtrl.regWrite));
  regDstRule: assert property (@(posedge clk) disable iff (rst)
    (regCtrl.regWrite && phase == EXEC2) |-> (regCtrl.regDst == (refCls == CLS_ALU_REG)))
    else reportValue("regDst", $sampled(refCls == CLS_ALU_REG), $sampled(regCtrl.regDst));
  aluOpRule: assert property (@(posedge clk) disable iff (rst)
    (phase == EXEC1) |-> (aluCtrl.aluOp == expAluOp))
    else reportValue("EXEC1 aluOp", $sampled(expAluOp), $sampled(aluCtrl.aluOp));
  extSelRule: assert property (@(posedge clk) disable iff (rst) aluCtrl.extSel == expExtSel)
    else reportValue("extSel", $sampled(expExtSel), $sampled(aluCtrl.extSel));
  memReadRule: assert property (@(posedge clk) disable iff (rst)
    memCtrl.memRead == expMemRead)
    else reportValue("memRead", $sampled(expMemRead), $sampled(memCtrl.memRead));
  memWriteRule: assert property (@(posedge clk) disable iff (rst)
    memCtrl.memWrite == expMemWrite)
    else reportValue("memWrite", $sampled(expMemWrite), $sampled(memCtrl.memWrite));
  dataAccess: assert property (@(posedge clk) disable iff (rst)
    (phase == EXEC2 && refCls inside {CLS_LOAD, CLS_STORE})
    |-> ({memCtrl.iOrD, memCtrl.byteEnable, memCtrl.extMode} == {1'b1, expByteEn, expExt}))
    else reportValue("data access", $sampled({1'b1, expByteEn, expExt}),
                     $sampled({memCtrl.iOrD, memCtrl.byteEnable, memCtrl.extMode}));
  branchRedirect: assert property (@(posedge clk) disable iff (rst)
    (phase == FETCH) |-> (pcCtrl.pcSrc == expDelay))
    else reportValue("fetch pcSrc", $sampled(expDelay), $sampled(pcCtrl.pcSrc));

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    seed = 45924;
    errorCount = 0;
    instrCount = 0;
    fetching = 1'b0;
    nextInstr = '0;
    rst = 1'b1;
    run = 1'b0;
    instr = '0;
    pcIsZero = 1'b0;
    waitRequest = 1'b0;
    aluFlag = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // Stays halted and quiet until run
    repeat (4) @(posedge clk);
    run <= 1'b1;
    @(posedge clk);
    run <= 1'b0;
    while (instrCount < NUM_INSTR) begin
      @(negedge clk);
      fetching = (phase == FETCH);
      @(posedge clk);
      waitRequest <= ($random(seed) & 3) == 0;
      aluFlag <= ($random(seed) & 1) != 0;
      pcIsZero <= ($random(seed) & 63) == 0;
      run <= ($random(seed) & 3) == 0;
      // New word takes effect as the machine leaves FETCH
      if (fetching) begin
        pickInstr(nextInstr);
        instr <= nextInstr;
        instrCount++;
      end
    end
    repeat (4) @(posedge clk);
    $display("Checks failed: %0d", errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(NUM_INSTR * 12 * CLK_PERIOD);
    $display("Watchdog expired before %0d instructions ran", NUM_INSTR);
    $display("Checks failed: %0d", errorCount);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
